//--- src.f
hw/sdram_disp_pkg.sv
hw/hex_seg_decoder.sv
hw/sdram_poll_master.sv
hw/sdram_disp_top.sv
sim/avalon_sdram_model.sv
sim/tb_sdram_disp.sv

//--- Makefile
# Verilator build and run for the SDRAM display poller testbench

VERILATOR   ?= verilator
TOP         ?= tb_sdram_disp
FILELIST    ?= src.f
BUILD_DIR   ?= obj_dir
POLL_CYCLES ?= 16
VFLAGS      ?= --binary --timing
PARAMS      ?= -GPOLL_CYCLES=$(POLL_CYCLES)

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) $(PARAMS) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status is non-zero when the testbench stops with $fatal
run: $(BINARY)
	./$(BINARY)

clean:
	rm -rf $(BUILD_DIR)

//--- sim/tb_sdram_disp.sv
`timescale 1ns/1ps

// Testbench for the SDRAM display poller. An Avalon-MM slave model serves
// the polled word, the testbench changes it between polls and follows the
// bus and the HEX outputs at every falling edge.
module tb_sdram_disp #(
	parameter sdram_disp_pkg::addr_t POLL_ADDR   = 26'h10000,
	parameter integer                POLL_CYCLES = 16
);

	import sdram_disp_pkg::*;

	localparam logic [31:0] SEED           = 32'h931156c3;
	localparam int          NUM_WORDS      = 12; // Four fixed, the rest random
	localparam int          TIMEOUT_CYCLES = 40 * (POLL_CYCLES + 12) * NUM_WORDS;

	// Digits that light each segment, bit n set for digit n
	localparam logic [15:0] SEG_A_DIGITS = 16'hD7ED;
	localparam logic [15:0] SEG_B_DIGITS = 16'h279F;
	localparam logic [15:0] SEG_C_DIGITS = 16'h2FFB;
	localparam logic [15:0] SEG_D_DIGITS = 16'h7B6D;
	localparam logic [15:0] SEG_E_DIGITS = 16'hFD45;
	localparam logic [15:0] SEG_F_DIGITS = 16'hDF71;
	localparam logic [15:0] SEG_G_DIGITS = 16'hEF7C;

	logic  clk = 1'b0;
	logic  rst_n = 1'b0;
	addr_t master_address;
	logic  master_read;
	logic  master_waitrequest;
	word_t master_readdata;
	logic  master_readdatavalid;
	seg_t  HEX0;
	seg_t  HEX1;
	seg_t  HEX2;
	seg_t  HEX3;

	word_t       words [NUM_WORDS];
	word_t       loaded_word = '0; // Returned by the next read
	word_t       shown_word = '0; // Expected on the display
	logic [31:0] rng = SEED;
	int          rdv_count = 0; // Completed reads
	int          gap = 0; // Idle cycles since the last read ended
	logic        counting = 1'b0;
	logic        outstanding = 1'b0; // Read accepted, no data yet
	logic        held_request = 1'b0; // Stalled request at the last sample
	addr_t       prev_addr = '0;
	int          cycle_count = 0;

	always #10 clk = ~clk;

	sdram_disp_top #(
		.POLL_ADDR   (POLL_ADDR),
		.POLL_CYCLES (POLL_CYCLES)
	) sdram_disp_top_inst (
		.clk                  (clk),
		.rst_n                (rst_n),
		.master_address       (master_address),
		.master_read          (master_read),
		.master_waitrequest   (master_waitrequest),
		.master_readdata      (master_readdata),
		.master_readdatavalid (master_readdatavalid),
		.HEX0                 (HEX0),
		.HEX1                 (HEX1),
		.HEX2                 (HEX2),
		.HEX3                 (HEX3)
	);

	avalon_sdram_model #(
		.SEED (SEED)
	) sdram_model_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.address       (master_address),
		.read          (master_read),
		.waitrequest   (master_waitrequest),
		.readdata      (master_readdata),
		.readdatavalid (master_readdatavalid)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Expected segments of one digit, abcdefg with a in bit 6
	function automatic seg_t seg_ref(input nibble_t n);
		return {SEG_A_DIGITS[n], SEG_B_DIGITS[n], SEG_C_DIGITS[n], SEG_D_DIGITS[n],
			SEG_E_DIGITS[n], SEG_F_DIGITS[n], SEG_G_DIGITS[n]};
	endfunction

	// HEX3..HEX0 for a whole word
	function automatic logic [27:0] display_ref(input word_t w);
		return {seg_ref(w[15:12]), seg_ref(w[11:8]), seg_ref(w[7:4]), seg_ref(w[3:0])};
	endfunction

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("error at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
				expected);
			$display("Something failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic wait_for_reads(input int n);
		while (rdv_count < n) begin
			@(posedge clk);
		end
	endtask

	// Word for the next poll, placed 1 ns after an edge
	task automatic load_poll_word(input word_t w);
		loaded_word = w;
		sdram_model_inst.load_word(POLL_ADDR, w);
	endtask

	// Bus and display monitor, all outputs are stable at the falling edge
	always @(negedge clk) begin
		check_eq(32'({HEX3, HEX2, HEX1, HEX0}), 32'(display_ref(shown_word)), "display");
		if (!rst_n) begin
			check_eq(32'(master_read), 32'd0, "read during reset");
		end
		if (held_request) begin
			check_eq(32'(master_read), 32'd1, "read dropped under waitrequest");
			check_eq(32'(master_address), 32'(prev_addr), "address moved under waitrequest");
		end
		if (master_read) begin
			check_eq(32'(master_address), 32'(POLL_ADDR), "read address");
			check_eq(32'(outstanding), 32'd0, "second read while one is outstanding");
			if (counting) begin
				check_eq(32'(gap), 32'(POLL_CYCLES), "idle cycles before the read");
				counting = 1'b0;
			end
		end else if (counting) begin
			gap = gap + 1;
		end
		if (master_readdatavalid) begin
			check_eq(32'(outstanding), 32'd1, "readdatavalid without an accepted read");
			check_eq(32'(master_readdata), 32'(loaded_word), "read data from the model");
			outstanding = 1'b0;
			shown_word  = loaded_word; // Latched at the coming edge
			rdv_count   = rdv_count + 1;
			gap         = 0;
			counting    = 1'b1;
		end
		if (master_read && !master_waitrequest) begin
			outstanding = 1'b1; // Accepted at the coming edge
		end
		if (!rst_n) begin
			gap         = 0; // Interval also runs from reset
			counting    = 1'b1;
			outstanding = 1'b0;
		end
		held_request = master_read && master_waitrequest;
		prev_addr    = master_address;
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Something failed");
			$fatal(1, "timeout after %0d cycles with %0d of %0d reads done", cycle_count,
				rdv_count, NUM_WORDS);
		end
	end

	initial begin
		// Fixed words cover all sixteen digits
		words[0] = 16'h0123;
		words[1] = 16'h4567;
		words[2] = 16'h89AB;
		words[3] = 16'hCDEF;
		for (int i = 4; i < NUM_WORDS; i++) begin
			rng      = lcg_next(rng);
			words[i] = rng[31:16];
		end

		repeat (16) @(posedge clk);
		#1;
		load_poll_word(words[0]);
		rst_n = 1'b1;

		for (int i = 1; i < NUM_WORDS; i++) begin
			wait_for_reads(i);
			#1 load_poll_word(words[i]); // Between polls
		end
		wait_for_reads(NUM_WORDS);
		repeat (2) @(posedge clk); // Last display update gets checked

		$display("Everything OK");
		$finish;
	end

endmodule

//--- sim/avalon_sdram_model.sv
`timescale 1ns/1ps

// Behavioral Avalon-MM SDRAM slave. One read at a time, with a random
// number of waitrequest stall cycles before acceptance and a random read
// latency before the single readdatavalid pulse.
module avalon_sdram_model #(
	parameter logic [31:0] SEED = 32'h931156c3
) (
	input  logic                  clk,
	input  logic                  rst_n,

	// Avalon-MM slave side
	input  sdram_disp_pkg::addr_t address,
	input  logic                  read,
	output logic                  waitrequest,
	output sdram_disp_pkg::word_t readdata,
	output logic                  readdatavalid
);

	import sdram_disp_pkg::*;

	localparam int DEPTH = 16; // Words, indexed by the low address bits

	word_t       mem [DEPTH];
	logic [31:0] rng; // LCG state
	logic [1:0]  stall; // Waitrequest cycles beyond the first
	logic [2:0]  latency; // Edges from acceptance to readdatavalid
	addr_t       req_addr; // Address of the read in flight

	// Linear congruential step, full 32-bit state
	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Store one word, used by the testbench between polls
	task load_word(input addr_t addr, input word_t value);
		mem[addr[3:0]] = value;
	endtask

	initial begin
		waitrequest   = 1'b1; // Idle bus holds off any request
		readdata      = '0;
		readdatavalid = 1'b0;
		rng           = SEED;
		stall         = '0;
		latency       = 3'd1;
		req_addr      = '0;

		// Every word differs, built from the whole index
		for (int i = 0; i < DEPTH; i++) begin
			mem[i[3:0]] = {i[3:0], ~i[3:0], i[3:0] ^ 4'h5, 4'hA - i[3:0]};
		end

		forever begin
			// Inputs are sampled half a cycle before the edge they act on
			@(negedge clk);
			if (rst_n && read) begin
				req_addr = address; // Master holds it until acceptance
				rng      = lcg_step(rng);
				stall    = rng[31:30];
				latency  = {1'b0, rng[29:28]} + 3'd1;

				@(posedge clk); // First edge with the read, always stalled
				repeat (stall) @(posedge clk);
				#1 waitrequest = 1'b0;

				@(posedge clk); // Read accepted on this edge
				#1 waitrequest = 1'b1;

				if (latency > 3'd1) begin
					repeat (latency - 3'd1) @(posedge clk);
					#1;
				end
				readdata      = mem[req_addr[3:0]];
				readdatavalid = 1'b1;

				@(posedge clk); // Single cycle pulse
				#1 readdatavalid = 1'b0;

				// Junk on the data lines, the master must ignore it
				rng      = lcg_step(rng);
				readdata = rng[15:0];
			end
		end
	end

endmodule

//--- hw/sdram_disp_top.sv
`timescale 1ns/1ps

// SDRAM word poller with a four digit hex display
module sdram_disp_top #(
	parameter sdram_disp_pkg::addr_t POLL_ADDR   = 26'h10000,
	parameter integer                POLL_CYCLES = 16
) (
	input  logic                  clk,
	input  logic                  rst_n,

	// Avalon-MM read master, to the SDRAM controller
	output sdram_disp_pkg::addr_t master_address,
	output logic                  master_read,
	input  logic                  master_waitrequest,
	input  sdram_disp_pkg::word_t master_readdata,
	input  logic                  master_readdatavalid,

	// Seven-segment digits, HEX0 is the least significant
	output sdram_disp_pkg::seg_t  HEX0,
	output sdram_disp_pkg::seg_t  HEX1,
	output sdram_disp_pkg::seg_t  HEX2,
	output sdram_disp_pkg::seg_t  HEX3
);

	import sdram_disp_pkg::*;

	word_t data; // Latched word from the master

	sdram_poll_master #(
		.POLL_ADDR   (POLL_ADDR),
		.POLL_CYCLES (POLL_CYCLES)
	) sdram_poll_master_inst (
		.clk                  (clk),
		.rst_n                (rst_n),
		.master_address       (master_address),
		.master_read          (master_read),
		.master_waitrequest   (master_waitrequest),
		.master_readdata      (master_readdata),
		.master_readdatavalid (master_readdatavalid),
		.data                 (data)
	);

	hex_seg_decoder digit_0 (
		.x (data[3:0]),
		.z (HEX0)
	);

	hex_seg_decoder digit_1 (
		.x (data[7:4]),
		.z (HEX1)
	);

	hex_seg_decoder digit_2 (
		.x (data[11:8]),
		.z (HEX2)
	);

	hex_seg_decoder digit_3 (
		.x (data[15:12]),
		.z (HEX3)
	);

endmodule

//--- hw/sdram_poll_master.sv
`timescale 1ns/1ps

// Polls a single SDRAM word over Avalon-MM. One read in flight at a time,
// a fixed idle interval between the end of one read and the next request.
module sdram_poll_master #(
	parameter sdram_disp_pkg::addr_t POLL_ADDR   = 26'h10000,
	parameter integer                POLL_CYCLES = 16
) (
	input  logic                  clk,
	input  logic                  rst_n,

	// Avalon-MM read master
	output sdram_disp_pkg::addr_t master_address,
	output logic                  master_read,
	input  logic                  master_waitrequest,
	input  sdram_disp_pkg::word_t master_readdata,
	input  logic                  master_readdatavalid,

	// Last word read back
	output sdram_disp_pkg::word_t data
);

	import sdram_disp_pkg::*;

	// Counter only has to reach POLL_CYCLES-1
	localparam integer CNT_W = (POLL_CYCLES > 1) ? $clog2(POLL_CYCLES) : 1;
	localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(POLL_CYCLES - 1);

	poll_state_t state;
	poll_state_t state_next;

	logic [CNT_W-1:0] wait_cnt; // Remaining idle cycles
	logic             wait_done; // Last idle cycle
	logic             accept; // Read taken by the slave
	logic             rsp_valid; // Word returned for our read

	word_t data_q;
	logic  read_q;

	assign wait_done = (state == POLL_WAIT) && (wait_cnt == '0);
	assign accept    = (state == POLL_REQ) && read_q && !master_waitrequest;
	assign rsp_valid = (state == POLL_DATA) && master_readdatavalid;

	// Next state
	always_comb begin
		state_next = state;
		case (state)
			POLL_WAIT: begin
				if (wait_done) begin
					state_next = POLL_REQ;
				end
			end
			POLL_REQ: begin
				if (accept) begin
					state_next = POLL_DATA;
				end
			end
			POLL_DATA: begin
				if (rsp_valid) begin
					state_next = POLL_WAIT;
				end
			end
			default: begin
				state_next = POLL_WAIT;
			end
		endcase
	end

	// State register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= POLL_WAIT;
		end else begin
			state <= state_next;
		end
	end

	// Interval counter, reloaded when the read completes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wait_cnt <= CNT_LOAD;
		end else if (rsp_valid) begin
			wait_cnt <= CNT_LOAD; // Restart the idle interval
		end else if (state == POLL_WAIT && !wait_done) begin
			wait_cnt <= wait_cnt - CNT_W'(1);
		end
	end

	// Request side of the bus.
	// Read holds while waitrequest is high, since it only changes on
	// entry to POLL_REQ and on acceptance. The address never changes.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			read_q <= 1'b0;
		end else begin
			if (wait_done) begin
				read_q <= 1'b1; // Issue the read
			end else if (accept) begin
				read_q <= 1'b0; // Drop after acceptance
			end
		end
	end

	// Latch the returned word
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			data_q <= '0; // Display shows 0000 until the first read
		end else if (rsp_valid) begin
			data_q <= master_readdata;
		end
	end

	assign master_read    = read_q;
	assign master_address = POLL_ADDR;
	assign data           = data_q;

endmodule

//--- hw/hex_seg_decoder.sv
`timescale 1ns/1ps

// Hex digit to seven-segment pattern, abcdefg with a in bit 6, active high
module hex_seg_decoder (
	input  sdram_disp_pkg::nibble_t x,
	output sdram_disp_pkg::seg_t    z
);

	always_comb begin
		case (x)
			4'h0: z = 7'b1111110; // 0
			4'h1: z = 7'b0110000; // 1
			4'h2: z = 7'b1101101; // 2
			4'h3: z = 7'b1111001; // 3
			4'h4: z = 7'b0110011; // 4
			4'h5: z = 7'b1011011; // 5
			4'h6: z = 7'b1011111; // 6
			4'h7: z = 7'b1110000; // 7
			4'h8: z = 7'b1111111; // 8, all lit
			4'h9: z = 7'b1111011; // 9
			4'hA: z = 7'b1110111; // A
			4'hB: z = 7'b0011111; // b, lower case
			4'hC: z = 7'b1001110; // C
			4'hD: z = 7'b0111101; // d, lower case
			4'hE: z = 7'b1001111; // E
			4'hF: z = 7'b1000111; // F
			default: z = 7'b0000000; // Blank
		endcase
	end

endmodule

//--- hw/sdram_disp_pkg.sv
package sdram_disp_pkg;

	// Bus and display widths
	localparam int ADDR_W   = 26; // Avalon word address
	localparam int WORD_W   = 16; // SDRAM data word
	localparam int NIBBLE_W = 4;  // One hex digit
	localparam int SEG_W    = 7;  // Segments a..g

	// Avalon word address into the SDRAM
	typedef logic [ADDR_W-1:0] addr_t;

	// Data word as returned by the memory
	typedef logic [WORD_W-1:0] word_t;

	// Single hexadecimal digit
	typedef logic [NIBBLE_W-1:0] nibble_t;

	// Segment pattern: bit 6 is a, bit 0 is g, 1 means lit
	typedef logic [SEG_W-1:0] seg_t;

	// Poll master FSM
	typedef enum logic [1:0] {
		POLL_WAIT, // Interval countdown
		POLL_REQ,  // Read asserted, waiting for acceptance
		POLL_DATA  // Read accepted, waiting for readdatavalid
	} poll_state_t;

endpackage
